//--- Bender.yml
package:
  name: gfx_layers

sources:
  - gfx_pkg.sv
  - tile_rom_if.sv
  - tile_vram.sv
  - tilemap_render.sv
  - rom_arbiter.sv
  - line_mixer.sv
  - gfx_layers.sv
  - target: test
    files:
      - gfx_layers_tb.sv

//--- gfx_layers.f
gfx_pkg.sv
tile_rom_if.sv
tile_vram.sv
tilemap_render.sv
rom_arbiter.sv
line_mixer.sv
gfx_layers.sv
gfx_layers_tb.sv

//--- gfx_layers.sv
module gfx_layers import gfx_pkg::*; #(
    parameter int ROM_AW = gfx_pkg::ROM_AW
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              hs,
    input  logic              lvbl,
    input  logic [7:0]        vrender,
    input  logic [7:0]        hpos,
    input  logic [7:0]        bg_hscroll,
    input  logic [7:0]        bg_vscroll,
    input  logic [7:0]        fg_hscroll,
    input  logic [7:0]        fg_vscroll,
    input  logic              cpu_we,
    input  logic [10:0]       cpu_addr,
    input  logic [15:0]       cpu_din,
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ok,
    input  logic [15:0]       rom_data,
    output pixel_t            pixel,
    output logic              done
);
    logic [9:0]   bg_vram_addr;
    logic [9:0]   fg_vram_addr;
    tile_entry_t  bg_vram_data;
    tile_entry_t  fg_vram_data;
    logic         bg_we;
    logic         fg_we;
    logic [8:0]   bg_x;
    logic [8:0]   fg_x;
    layer_pixel_t bg_din;
    layer_pixel_t fg_din;
    logic         bg_done;
    logic         fg_done;

    tile_rom_if #(.AW(ROM_AW)) bg_rom ();
    tile_rom_if #(.AW(ROM_AW)) fg_rom ();

    assign done = bg_done & fg_done;

    tile_vram i_vram (
        .clk(clk), .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_din(cpu_din),
        .bg_addr(bg_vram_addr), .bg_data(bg_vram_data),
        .fg_addr(fg_vram_addr), .fg_data(fg_vram_data)
    );

    tilemap_render #(.LAYER_ID(0), .ROM_AW(ROM_AW)) i_bg (
        .clk(clk), .rst(rst), .hs(hs), .lvbl(lvbl), .vrender(vrender),
        .hscroll(bg_hscroll), .vscroll(bg_vscroll),
        .vram_addr(bg_vram_addr), .vram_data(bg_vram_data), .rom(bg_rom),
        .line_we(bg_we), .line_x(bg_x), .line_din(bg_din), .done(bg_done)
    );

    tilemap_render #(.LAYER_ID(1), .ROM_AW(ROM_AW)) i_fg (
        .clk(clk), .rst(rst), .hs(hs), .lvbl(lvbl), .vrender(vrender),
        .hscroll(fg_hscroll), .vscroll(fg_vscroll),
        .vram_addr(fg_vram_addr), .vram_data(fg_vram_data), .rom(fg_rom),
        .line_we(fg_we), .line_x(fg_x), .line_din(fg_din), .done(fg_done)
    );

    rom_arbiter #(.ROM_AW(ROM_AW)) i_arb (
        .clk(clk), .rst(rst), .bg(bg_rom), .fg(fg_rom),
        .rom_cs(rom_cs), .rom_addr(rom_addr), .rom_ok(rom_ok), .rom_data(rom_data)
    );

    line_mixer i_mixer (
        .clk(clk), .rst(rst), .hs(hs), .lvbl(lvbl),
        .bg_we(bg_we), .bg_x(bg_x), .bg_din(bg_din),
        .fg_we(fg_we), .fg_x(fg_x), .fg_din(fg_din),
        .hpos(hpos), .pixel(pixel)
    );

endmodule

//--- gfx_layers_tb.sv
module gfx_layers_tb import gfx_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int LINE_CYCLES = 1500;
    localparam int HS_CYCLES   = 8;
    localparam int VIS_LINES   = 6;   // lvbl high for these lines
    localparam int RUN_LINES   = 7;   // one blanked line at the end
    localparam int READ_START  = 16;  // first readout cycle within a line
    localparam int VRAM_WORDS  = 2 * MAP_TILES * MAP_TILES;
    localparam int TIMEOUT     = 8 * LINE_CYCLES + VRAM_WORDS + 500;

    logic              clk = 1'b0;
    logic              rst;
    logic              hs;
    logic              lvbl;
    logic [7:0]        vrender;
    logic [7:0]        hpos;
    logic [7:0]        bg_hscroll;
    logic [7:0]        bg_vscroll;
    logic [7:0]        fg_hscroll;
    logic [7:0]        fg_vscroll;
    logic              cpu_we;
    logic [10:0]       cpu_addr;
    logic [15:0]       cpu_din;
    logic              rom_cs;
    logic [ROM_AW-1:0] rom_addr;
    logic              rom_ok;
    logic [15:0]       rom_data;
    pixel_t            pixel;
    logic              done;

    int                seed       = 32403;
    int                errors     = 0;
    int                checks     = 0;
    int                cycles     = 0;
    int                rom_wait   = 0;
    logic              cs_waiting = 1'b0;
    logic [ROM_AW-1:0] held_addr;
    logic [15:0]       vram_copy [VRAM_WORDS];
    logic [31:0]       scroll_log [RUN_LINES];  // bg h, bg v, fg h, fg v

    always #20 clk = ~clk;

    gfx_layers i_dut (.*);

    task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string msg);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    // fixed scramble of the address that stands in for the graphics ROM
    function automatic logic [15:0] rom_word(input logic [ROM_AW-1:0] a);
        logic [31:0] h;
        h = {17'd0, a} * 32'h9e3779b1;
        return h[31:16] ^ h[15:0];
    endfunction

    // palette and pen of one layer at screen x
    function automatic logic [7:0] layer_pixel(input logic layer, input logic [7:0] vr,
            input logic [7:0] hsc, input logic [7:0] vsc, input int x);
        logic [7:0]  vn;
        logic [7:0]  hn;
        logic [15:0] ent;
        logic [2:0]  t;
        logic [15:0] word;
        int          sh;
        vn   = vr + vsc;
        hn   = 8'(x) + hsc;
        ent  = vram_copy[{layer, vn[7:3], hn[7:3]}];
        t    = ent[14] ? ~hn[2:0] : hn[2:0];  // hflip mirrors the tile
        word = rom_word({layer, ent[9:0], vn[2:0], t[2]});
        sh   = 12 - 4 * int'(t[1:0]);          // leftmost pixel in the top nibble
        return {ent[13:10], word[sh +: 4]};
    endfunction

    function automatic logic [8:0] mixed_pixel(input int ln, input int x);
        logic [31:0] s;
        logic [7:0]  bg;
        logic [7:0]  fg;
        s  = scroll_log[ln];
        bg = layer_pixel(1'b0, 8'(ln), s[31:24], s[23:16], x);
        fg = layer_pixel(1'b1, 8'(ln), s[15:8], s[7:0], x);
        return (fg[3:0] != 4'd0) ? {1'b1, fg} : {1'b0, bg};
    endfunction

    task automatic load_vram();
        for (int a = 0; a < VRAM_WORDS; a++) begin
            @(negedge clk);
            cpu_we       = 1'b1;
            cpu_addr     = 11'(a);
            cpu_din      = 16'($random(seed));
            vram_copy[a] = cpu_din;
        end
        @(negedge clk);
        cpu_we = 1'b0;
    endtask

    // one video line that also reads back the line rendered before it
    task automatic run_line(input int ln);
        logic vis;
        int   i;
        vis = (ln < VIS_LINES);
        @(negedge clk);
        hs      = 1'b1;
        lvbl    = vis;
        vrender = 8'(ln);
        {bg_hscroll, bg_vscroll, fg_hscroll, fg_vscroll} = (ln == 0) ? 32'd0 : $random(seed);
        scroll_log[ln] = {bg_hscroll, bg_vscroll, fg_hscroll, fg_vscroll};
        for (int c = 1; c < LINE_CYCLES; c++) begin
            @(negedge clk);
            if (c == HS_CYCLES) hs = 1'b0;
            // no render starts while lvbl is low
            if (c == 1) compare(done, !vis, $sformatf("done after hs of line %0d", ln));
            i = c - READ_START;
            if (ln > 0 && ln < VIS_LINES && i >= 0 && i <= LINE_PIXELS) begin
                if (i > 0) begin
                    compare(pixel, mixed_pixel(ln - 1, i - 1),
                        $sformatf("pixel of line %0d at x %0d", ln - 1, i - 1));
                end
                if (i < LINE_PIXELS) hpos = 8'(i);  // pixel shows one cycle later
            end
        end
        compare(done, 1'b1, $sformatf("done high before hs after line %0d", ln));
    endtask

    // ROM model answers after 0 to 7 cycles
    always @(negedge clk) begin
        if (cs_waiting) begin
            compare(rom_cs, 1'b1, "rom_cs dropped before rom_ok");
            compare(rom_addr, held_addr, "rom_addr changed while waiting");
        end
        if (rom_ok) begin
            rom_ok   = 1'b0;  // taken at the last rising edge
            rom_wait = $random(seed) & 7;
        end else if (rom_cs) begin
            if (rom_wait == 0) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr);
            end else begin
                rom_wait = rom_wait - 1;
            end
        end
        cs_waiting = rom_cs && !rom_ok;
        held_addr  = rom_addr;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT) begin
            errors = errors + 1;
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        rst      = 1'b1;
        hs       = 1'b0;
        lvbl     = 1'b0;
        vrender  = '0;
        hpos     = '0;
        rom_ok   = 1'b0;
        rom_data = '0;
        {bg_hscroll, bg_vscroll, fg_hscroll, fg_vscroll} = '0;
        {cpu_we, cpu_addr, cpu_din} = '0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        compare(done, 1'b1, "done high after reset");
        compare(rom_cs, 1'b0, "rom_cs low after reset");
        load_vram();
        for (int ln = 0; ln < RUN_LINES; ln++) begin
            run_line(ln);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

//--- gfx_pkg.sv
package gfx_pkg;

    localparam int LINE_PIXELS = 256;  // visible pixels per line
    localparam int MAP_TILES   = 32;   // tiles per map row and column
    // layer, tile code, tile row, half
    localparam int ROM_AW      = 15;

    // one word of tile RAM
    typedef struct packed {
        logic       spare;
        logic       hflip;
        logic [3:0] pal;
        logic [9:0] code;
    } tile_entry_t;

    // pixel as written by one layer
    typedef struct packed {
        logic [3:0] pal;
        logic [3:0] pen;
    } layer_pixel_t;

    typedef struct packed {
        logic       layer;  // 1 for foreground
        logic [3:0] pal;
        logic [3:0] pen;
    } pixel_t;

    typedef enum logic [2:0] {
        IDLE, TILE_ADDR, TILE_READ, ROM_REQ, ROM_WAIT, DUMP, NEXT
    } render_state_t;

endpackage

//--- line_mixer.sv
module line_mixer import gfx_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         hs,
    input  logic         lvbl,
    input  logic         bg_we,
    input  logic [8:0]   bg_x,
    input  layer_pixel_t bg_din,
    input  logic         fg_we,
    input  logic [8:0]   fg_x,
    input  layer_pixel_t fg_din,
    input  logic [7:0]   hpos,
    output pixel_t       pixel
);
    localparam int XW = $clog2(LINE_PIXELS);

    // two lines per layer, indexed by {bank, x}
    layer_pixel_t bg_buf [2*LINE_PIXELS];
    layer_pixel_t fg_buf [2*LINE_PIXELS];
    layer_pixel_t bg_rd;
    layer_pixel_t fg_rd;
    logic         line;     // bank being written this line
    logic         last_hs;

    always_ff @(posedge clk) begin
        if (rst) begin
            line    <= 1'b0;
            last_hs <= 1'b0;
        end else begin
            last_hs <= hs;
            if (hs && !last_hs && lvbl) line <= ~line;
        end
    end

    always_ff @(posedge clk) begin
        if (bg_we && !bg_x[8]) bg_buf[{line, bg_x[XW-1:0]}] <= bg_din;
        if (fg_we && !fg_x[8]) fg_buf[{line, fg_x[XW-1:0]}] <= fg_din;
    end

    // read the other bank, it holds the previous line
    always_ff @(posedge clk) begin
        bg_rd <= bg_buf[{~line, hpos}];
        fg_rd <= fg_buf[{~line, hpos}];
    end

    // pen 0 of the foreground is see-through
    always_comb begin
        if (fg_rd.pen != 4'd0) begin
            pixel = {1'b1, fg_rd};
        end else begin
            pixel = {1'b0, bg_rd};
        end
    end

endmodule

//--- rom_arbiter.sv
module rom_arbiter #(
    parameter int ROM_AW = 15
) (
    input  logic              clk,
    input  logic              rst,
    tile_rom_if.arbiter       bg,
    tile_rom_if.arbiter       fg,
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr,
    input  logic              rom_ok,
    input  logic [15:0]       rom_data
);
    logic busy;   // a request is in flight
    logic owner;  // layer served last (1 is fg)
    logic pick;
    logic sel;

    // round robin when both layers ask at once
    always_comb begin
        pick = owner;
        if (bg.req && fg.req) begin
            pick = ~owner;
        end else if (fg.req) begin
            pick = 1'b1;
        end else if (bg.req) begin
            pick = 1'b0;
        end
    end

    assign sel      = busy ? owner : pick;
    assign rom_cs   = sel ? fg.req : bg.req;
    assign rom_addr = sel ? fg.addr : bg.addr;

    assign bg.ok   = rom_ok && rom_cs && !sel;
    assign fg.ok   = rom_ok && rom_cs && sel;
    assign bg.data = sel ? '0 : rom_data;
    assign fg.data = sel ? rom_data : '0;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy  <= 1'b0;
            owner <= 1'b0;
        end else begin
            busy <= rom_cs && !rom_ok;  // also frees the ROM if a requester gives up
            if (rom_cs && !busy) owner <= sel;
        end
    end

    // each ROM answer reaches exactly one layer
    a_single_ok: assert property (@(posedge clk) disable iff (rst)
        rom_ok |-> bg.ok ^ fg.ok);

    a_owner_held: assert property (@(posedge clk) disable iff (rst)
        rom_cs && !rom_ok |=> sel == $past(sel));

endmodule

//--- tile_rom_if.sv
// one renderer's path to the graphics ROM
// req is held with a steady addr until ok comes back
interface tile_rom_if #(
    parameter int AW = 15
) ();
    logic          req;
    logic [AW-1:0] addr;
    logic          ok;    // data valid in this cycle
    logic [15:0]   data;

    modport renderer (output req, output addr, input ok, input data);
    modport arbiter (input req, input addr, output ok, output data);
endinterface

//--- tile_vram.sv
module tile_vram import gfx_pkg::*; (
    input  logic        clk,
    input  logic        cpu_we,
    input  logic [10:0] cpu_addr,  // layer, row, column
    input  logic [15:0] cpu_din,
    input  logic [9:0]  bg_addr,
    output tile_entry_t bg_data,
    input  logic [9:0]  fg_addr,
    output tile_entry_t fg_data
);
    localparam int DEPTH = 2 * MAP_TILES * MAP_TILES;

    // lower half holds the background map, upper half the foreground
    tile_entry_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_din;
        end
    end

    // registered reads, a write shows up one cycle later
    always_ff @(posedge clk) begin
        bg_data <= mem[{1'b0, bg_addr}];
        fg_data <= mem[{1'b1, fg_addr}];
    end

endmodule

//--- tilemap_render.sv
module tilemap_render import gfx_pkg::*; #(
    parameter int LAYER_ID = 0,
    parameter int ROM_AW   = 15
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         hs,
    input  logic         lvbl,
    input  logic [7:0]   vrender,
    input  logic [7:0]   hscroll,
    input  logic [7:0]   vscroll,
    output logic [9:0]   vram_addr,
    input  tile_entry_t  vram_data,
    tile_rom_if.renderer rom,
    output logic         line_we,
    output logic [8:0]   line_x,
    output layer_pixel_t line_din,
    output logic         done
);
    render_state_t     st;
    logic              last_hs;
    logic              line_start;
    logic [7:0]        vn;        // scrolled line, map row and tile row
    logic [7:0]        hn;        // scrolled column, one tile per step
    logic signed [8:0] x;         // write position, negative for the fine scroll
    logic [5:0]        tile_cnt;
    logic [9:0]        code;
    logic [3:0]        pal;
    logic              hflip;
    logic              half;      // which 4 pixels of the tile row
    logic [15:0]       pxl;
    logic [1:0]        dump_cnt;

    assign line_start = hs && !last_hs && lvbl;
    assign vram_addr  = {vn[7:3], hn[7:3]};
    assign rom.addr   = ROM_AW'({1'(LAYER_ID), code, vn[2:0], half});

    always_ff @(posedge clk) begin
        if (rst) begin
            st      <= IDLE;
            done    <= 1'b1;
            last_hs <= 1'b0;
            rom.req <= 1'b0;
            line_we <= 1'b0;
        end else begin
            last_hs <= hs;
            line_we <= 1'b0;
            if (line_start) begin
                done     <= 1'b0;
                st       <= IDLE;
                rom.req  <= 1'b0;
                vn       <= vrender + vscroll;
                hn       <= hscroll;
                x        <= -$signed({6'd0, hscroll[2:0]});
                tile_cnt <= '0;
            end else begin
                case (st)
                    IDLE: begin
                        if (!done) st <= TILE_ADDR;
                    end
                    TILE_ADDR: st <= TILE_READ;  // entry is back next cycle
                    TILE_READ: begin
                        code  <= vram_data.code;
                        pal   <= vram_data.pal;
                        hflip <= vram_data.hflip;
                        half  <= vram_data.hflip;  // flipped tiles start on the right half
                        st    <= ROM_REQ;
                    end
                    ROM_REQ: begin
                        rom.req <= 1'b1;
                        st      <= ROM_WAIT;
                    end
                    ROM_WAIT: begin
                        if (rom.ok) begin
                            pxl      <= rom.data;
                            rom.req  <= 1'b0;
                            dump_cnt <= '0;
                            st       <= DUMP;
                        end
                    end
                    DUMP: begin
                        line_we      <= !x[8];  // only 0..255 reach the buffer
                        line_x       <= x;
                        line_din.pal <= pal;
                        line_din.pen <= hflip ? pxl[3:0] : pxl[15:12];
                        pxl          <= hflip ? pxl >> 4 : pxl << 4;
                        x            <= x + 9'sd1;
                        dump_cnt     <= dump_cnt + 2'd1;
                        if (dump_cnt == 2'd3) st <= NEXT;
                    end
                    NEXT: begin
                        if (half == hflip) begin
                            // second word of the same tile
                            half <= ~half;
                            st   <= ROM_REQ;
                        end else begin
                            hn       <= hn + 8'd8;
                            tile_cnt <= tile_cnt + 6'd1;
                            if (tile_cnt == MAP_TILES) begin  // 33 tiles cover the fine scroll
                                done <= 1'b1;
                                st   <= IDLE;
                            end else begin
                                st <= TILE_ADDR;
                            end
                        end
                    end
                    default: st <= IDLE;
                endcase
            end
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        rom.req && !rom.ok |=> !rom.req || $stable(rom.addr));

    a_no_write_done: assert property (@(posedge clk) disable iff (rst)
        done |-> !line_we);

endmodule
